// ==== sources.f ====
design/fetch_pkg.sv
design/inst_cache.sv
design/fetch_unit.sv
design/fetch_top.sv
verification/tb_clock.sv
verification/fetch_asserts.sv
verification/fetch_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= fetch_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
EXTRA_ARGS ?=
LINT_FLAGS ?= -Wall
SIM_ARGS   ?= +verilator+error+limit+1000

BUILD_FLAGS = --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) $(EXTRA_ARGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/fetch_tb.sv ====
`default_nettype none

module fetch_tb;

	import fetch_pkg::*;

	logic        clock;
	logic        rst;
	logic        wb_valid;
	logic [31:0] pc;
	logic [31:0] inst;
	logic        idu_valid;
	logic [31:0] mem_araddr;
	logic        mem_arvalid;
	logic        mem_arready;
	logic [31:0] mem_rdata;
	logic [1:0]  mem_rresp;
	logic        mem_rvalid;
	logic        mem_rready;
	logic [31:0] fetch_cycles;
	logic [31:0] cache_hits;
	logic [31:0] cache_misses;

	int                  seed = 32'h7ce3;
	int                  read_count;
	int                  passed;
	int                  failed;
	bit                  test_ok = 1'b1;
	bit                  model_valid [cache_lines];
	logic [tag_bits-1:0] model_tag [cache_lines];
	logic [31:0]         pool [8];

	tb_clock tb_clock_i (.clock(clock));

	fetch_top fetch_top_i (.*);

	// ######################################################################
	// Memory model
	// ######################################################################

	initial begin
		logic [1:0]  ar_delay;
		logic [1:0]  r_delay;
		logic [31:0] addr;
		mem_arready = 1'b0;
		mem_rvalid  = 1'b0;
		mem_rdata   = 32'h0;
		mem_rresp   = resp_okay;
		forever begin
			@(posedge clock);
			#1;
			if (!rst && mem_arvalid) begin
				ar_delay = 2'($random(seed));
				r_delay  = 2'($random(seed));
				repeat (ar_delay) begin
					@(posedge clock);
					#1;
				end
				addr        = mem_araddr;
				mem_arready = 1'b1;
				@(posedge clock);
				#1;
				mem_arready = 1'b0;
				read_count++;
				repeat (r_delay) begin
					@(posedge clock);
					#1;
				end
				mem_rdata  = addr ^ 32'h5a5a1234;
				mem_rvalid = 1'b1;
				// Beat is taken on the next edge
				check_word("mem_rready", {31'h0, mem_rready}, 32'h1);
				@(posedge clock);
				#1;
				mem_rvalid = 1'b0;
			end
		end
	end

	function automatic bit predict_hit(input logic [31:0] addr);
		if (addr >= sram_base && addr < sram_limit)
			return 1'b0;
		return model_valid[addr[5:2]] && model_tag[addr[5:2]] == addr[31:6];
	endfunction

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			test_ok = 1'b0;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_ok) begin
			passed++;
			$display("test %s: passed", name);
		end else begin
			failed++;
			$display("test %s: failed", name);
		end
		test_ok = 1'b1;
	endtask

	// Called one unit after a rising edge with the fetch unit idle
	task automatic fetch_and_check(input logic [31:0] addr);
		logic [31:0] hits0;
		logic [31:0] misses0;
		int          reads0;
		int          cycles;
		bit          cached;
		bit          hit;
		cached   = !(addr >= sram_base && addr < sram_limit);
		hit      = predict_hit(addr);
		hits0    = cache_hits;
		misses0  = cache_misses;
		reads0   = read_count;
		pc       = addr;
		wb_valid = 1'b1;
		@(posedge clock);
		#1;
		wb_valid = 1'b0;
		cycles   = 1;
		while (!idu_valid && cycles < 200) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (!idu_valid) begin
			$display("Fetch at pc %h got no idu_valid within 200 cycles", addr);
			test_ok = 1'b0;
			return;
		end
		if (cached && !hit) begin
			model_valid[addr[5:2]] = 1'b1;
			model_tag[addr[5:2]]   = addr[31:6];
		end
		check_word("inst", inst, addr ^ 32'h5a5a1234);
		check_word("cache_hits delta", cache_hits - hits0, {31'h0, hit});
		check_word("cache_misses delta", cache_misses - misses0, {31'h0, cached && !hit});
		check_word("memory read count delta", read_count - reads0, {31'h0, !hit});
		if (hit)
			check_word("idu_valid latency", cycles, 4);
	endtask

	// ######################################################################
	// Test sequence
	// ######################################################################

	initial begin
		logic [31:0] hits0;
		logic [31:0] misses0;
		logic [31:0] cycles0;
		logic [31:0] addr;
		int          hits_exp;
		int          misses_exp;
		int unsigned assert_fails;
		rst      = 1'b1;
		wb_valid = 1'b0;
		pc       = 32'h0;
		pool[0]  = 32'h00001044;
		pool[1]  = 32'h00005044;
		pool[2]  = 32'h00002008;
		pool[3]  = 32'h0000200c;
		pool[4]  = 32'h00003008;
		pool[5]  = sram_base + 32'h4;
		pool[6]  = sram_base + 32'h1ffc;
		pool[7]  = 32'h80000010;
		repeat (8) @(posedge clock);
		#1;
		rst = 1'b0;

		repeat (12) begin
			@(posedge clock);
			#1;
			check_word("idu_valid", {31'h0, idu_valid}, 32'h0);
		end
		check_word("fetch_cycles", fetch_cycles, 32'h0);
		check_word("cache_hits", cache_hits, 32'h0);
		check_word("cache_misses", cache_misses, 32'h0);
		check_word("memory read count", read_count, 32'h0);
		finish_test("1 idle after reset");

		fetch_and_check(32'h00001044);
		finish_test("2 first fetch misses");
		fetch_and_check(32'h00001044);
		finish_test("3 repeat fetch hits");
		// Same index, other tag, then back
		fetch_and_check(32'h00005044);
		fetch_and_check(32'h00001044);
		finish_test("4 conflict eviction");
		fetch_and_check(sram_base + 32'h100);
		fetch_and_check(sram_base + 32'h100);
		finish_test("5 SRAM bypass");

		hits0      = cache_hits;
		misses0    = cache_misses;
		cycles0    = fetch_cycles;
		hits_exp   = 0;
		misses_exp = 0;
		repeat (40) begin
			addr = pool[3'($random(seed))];
			if (predict_hit(addr))
				hits_exp++;
			else if (!(addr >= sram_base && addr < sram_limit))
				misses_exp++;
			fetch_and_check(addr);
		end
		check_word("cache_hits total", cache_hits - hits0, hits_exp);
		check_word("cache_misses total", cache_misses - misses0, misses_exp);
		assert (fetch_cycles != 32'h0 && fetch_cycles > cycles0)
		else begin
			$display("FAIL fetch_cycles: got %h, start %h", fetch_cycles, cycles0);
			test_ok = 1'b0;
		end
		finish_test("6 random fetches");

		assert_fails = fetch_top_i.fetch_unit_i.fetch_asserts_i.fail_total;
		$display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
			passed, failed, assert_fails);
		if (failed == 0 && assert_fails == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/fetch_asserts.sv ====
`default_nettype none

module fetch_asserts (
	input logic                    clock,
	input logic                    rst,
	input fetch_pkg::fetch_state_t state,
	input logic                    pc_in_sram,
	input logic                    idu_valid,
	input logic [31:0]             mem_araddr,
	input logic                    mem_arvalid,
	input logic                    mem_arready,
	input logic [31:0]             cache_araddr,
	input logic                    cache_arvalid,
	input logic                    cache_arready,
	input logic [31:0]             cache_awaddr,
	input logic                    cache_awvalid,
	input logic                    cache_awready,
	input logic                    cache_wvalid,
	input logic                    cache_wready
);

	import fetch_pkg::*;

	int unsigned mem_ar_fails;
	int unsigned cache_ar_fails;
	int unsigned fill_fails;
	int unsigned pulse_fails;
	int unsigned reset_fails;
	int unsigned pair_fails;
	int unsigned bypass_fails;
	int unsigned fail_total;

	assign fail_total = mem_ar_fails + cache_ar_fails + fill_fails + pulse_fails
		+ reset_fails + pair_fails + bypass_fails;

	// ######################################################################
	// Channel handshakes
	// ######################################################################

	assert property (@(posedge clock) disable iff (rst)
			mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
		else begin
			$error("mem_arvalid or mem_araddr changed before mem_arready");
			mem_ar_fails++;
		end

	assert property (@(posedge clock) disable iff (rst)
			cache_arvalid && !cache_arready |=> cache_arvalid && $stable(cache_araddr))
		else begin
			$error("cache_arvalid or cache_araddr changed before cache_arready");
			cache_ar_fails++;
		end

	assert property (@(posedge clock) disable iff (rst)
			cache_awvalid && !(cache_awready && cache_wready)
			|=> cache_awvalid && cache_wvalid && $stable(cache_awaddr))
		else begin
			$error("Refill write dropped before both readies");
			fill_fails++;
		end

	// Address and data of a refill go out as one beat
	assert property (@(posedge clock) disable iff (rst)
			($rose(cache_awvalid) || $rose(cache_wvalid)) |-> cache_awvalid && cache_wvalid)
		else begin
			$error("cache_awvalid and cache_wvalid did not rise together");
			pair_fails++;
		end

	// ######################################################################
	// Fetch control
	// ######################################################################

	assert property (@(posedge clock) disable iff (rst) idu_valid |=> !idu_valid)
		else begin
			$error("idu_valid longer than one cycle");
			pulse_fails++;
		end

	assert property (@(posedge clock) $fell(rst) |-> state == st_idle && !idu_valid
			&& !mem_arvalid && !cache_arvalid && !cache_awvalid && !cache_wvalid)
		else begin
			$error("Fetch unit not idle in the first cycle after reset");
			reset_fails++;
		end

	assert property (@(posedge clock) disable iff (rst) cache_arvalid |-> !pc_in_sram)
		else begin
			$error("SRAM fetch went to the cache");
			bypass_fails++;
		end

endmodule

bind fetch_unit fetch_asserts fetch_asserts_i (.*);

`default_nettype wire

// ==== verification/tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic clock
);

	// Period of 4 time units
	initial begin
		clock = 1'b0;
		forever
			#2 clock = ~clock;
	end

endmodule

`default_nettype wire

// ==== design/fetch_top.sv ====
`default_nettype none

module fetch_top (
	input  logic        clock,
	input  logic        rst,

	input  logic        wb_valid,
	input  logic [31:0] pc,
	output logic [31:0] inst,
	output logic        idu_valid,

	output logic [31:0] mem_araddr,
	output logic        mem_arvalid,
	input  logic        mem_arready,
	input  logic [31:0] mem_rdata,
	input  logic [1:0]  mem_rresp,
	input  logic        mem_rvalid,
	output logic        mem_rready,

	output logic [31:0] fetch_cycles,
	output logic [31:0] cache_hits,
	output logic [31:0] cache_misses
);

	// Fetch unit to cache
	logic [31:0] cache_araddr;
	logic        cache_arvalid;
	logic        cache_arready;
	logic [31:0] cache_rdata;
	logic [1:0]  cache_rresp;
	logic        cache_rvalid;
	logic        cache_rready;
	logic [31:0] cache_awaddr;
	logic        cache_awvalid;
	logic        cache_awready;
	logic [31:0] cache_wdata;
	logic        cache_wvalid;
	logic        cache_wready;
	logic [1:0]  cache_bresp;
	logic        cache_bvalid;
	logic        cache_bready;

	// Port names match the local nets one for one
	fetch_unit fetch_unit_i (.*);

	inst_cache inst_cache_i (
		.clock   (clock),
		.rst     (rst),
		.araddr  (cache_araddr),
		.arvalid (cache_arvalid),
		.arready (cache_arready),
		.rdata   (cache_rdata),
		.rresp   (cache_rresp),
		.rvalid  (cache_rvalid),
		.rready  (cache_rready),
		.awaddr  (cache_awaddr),
		.awvalid (cache_awvalid),
		.awready (cache_awready),
		.wdata   (cache_wdata),
		.wvalid  (cache_wvalid),
		.wready  (cache_wready),
		.bresp   (cache_bresp),
		.bvalid  (cache_bvalid),
		.bready  (cache_bready)
	);

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`default_nettype none

module fetch_unit (
	input  logic        clock,
	input  logic        rst,

	input  logic        wb_valid,
	input  logic [31:0] pc,
	output logic [31:0] inst,
	output logic        idu_valid,

	output logic [31:0] mem_araddr,
	output logic        mem_arvalid,
	input  logic        mem_arready,
	input  logic [31:0] mem_rdata,
	input  logic [1:0]  mem_rresp,
	input  logic        mem_rvalid,
	output logic        mem_rready,

	output logic [31:0] cache_araddr,
	output logic        cache_arvalid,
	input  logic        cache_arready,
	input  logic [31:0] cache_rdata,
	input  logic [1:0]  cache_rresp,
	input  logic        cache_rvalid,
	output logic        cache_rready,

	output logic [31:0] cache_awaddr,
	output logic        cache_awvalid,
	input  logic        cache_awready,
	output logic [31:0] cache_wdata,
	output logic        cache_wvalid,
	input  logic        cache_wready,
	input  logic [1:0]  cache_bresp,
	input  logic        cache_bvalid,
	output logic        cache_bready,

	output logic [31:0] fetch_cycles,
	output logic [31:0] cache_hits,
	output logic [31:0] cache_misses
);

	import fetch_pkg::*;

	fetch_state_t state;
	fetch_state_t state_next;
	logic         pc_in_sram;
	logic         fill_sent;
	logic         cache_rfire;
	logic         cache_hit;
	logic         mem_rfire;
	logic         fill_fire;
	logic         fill_done;

	assign pc_in_sram = (pc >= sram_base) && (pc < sram_limit);

	// pc is held by writeback for the whole fetch
	assign cache_araddr = pc;
	assign cache_awaddr = pc;
	assign mem_araddr   = pc;
	assign cache_wdata  = inst;

	assign cache_rready = 1'b1;
	assign cache_bready = 1'b1;
	assign mem_rready   = 1'b1;

	assign cache_arvalid = (state == st_cache_addr);
	assign mem_arvalid   = (state == st_mem_addr);
	assign cache_awvalid = (state == st_fill) && !fill_sent;
	assign cache_wvalid  = (state == st_fill) && !fill_sent;

	assign cache_rfire = cache_rvalid && cache_rready;
	assign cache_hit   = cache_rfire && !cache_rresp[1];
	assign mem_rfire   = mem_rvalid && mem_rready;
	assign fill_fire   = cache_awvalid && cache_awready && cache_wvalid && cache_wready;
	assign fill_done   = cache_bvalid && cache_bready;

	always_comb begin
		state_next = state;
		case (state)
			st_idle:
				if (wb_valid)
					state_next = pc_in_sram ? st_mem_addr : st_cache_addr;
			st_cache_addr:
				if (cache_arready)
					state_next = st_cache_resp;
			st_cache_resp:
				if (cache_rfire)
					state_next = cache_rresp[1] ? st_mem_addr : st_done;
			st_mem_addr:
				if (mem_arready)
					state_next = st_mem_resp;
			st_mem_resp:
				// Error responses still deliver the word
				if (mem_rfire)
					state_next = pc_in_sram ? st_done : st_fill;
			st_fill:
				if (fill_done)
					state_next = st_done;
			st_done:
				state_next = st_idle;
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= st_idle;
			fill_sent <= 1'b0;
			idu_valid <= 1'b0;
			inst      <= 32'h0;
		end else begin
			state     <= state_next;
			idu_valid <= (state == st_done);
			// Refill write is issued once, then wait for bvalid
			if (state != st_fill)
				fill_sent <= 1'b0;
			else if (fill_fire)
				fill_sent <= 1'b1;
			if (state == st_cache_resp && cache_hit)
				inst <= cache_rdata;
			else if (state == st_mem_resp && mem_rfire)
				inst <= mem_rdata;
		end
	end

	// ######################################################################
	// Performance counters
	// ######################################################################

	always_ff @(posedge clock) begin
		if (rst) begin
			fetch_cycles <= 32'h0;
			cache_hits   <= 32'h0;
			cache_misses <= 32'h0;
		end else begin
			if (state != st_idle)
				fetch_cycles <= fetch_cycles + 32'd1;
			if (cache_hit)
				cache_hits <= cache_hits + 32'd1;
			if (cache_rfire && cache_rresp[1])
				cache_misses <= cache_misses + 32'd1;
		end
	end

endmodule

`default_nettype wire

// ==== design/inst_cache.sv ====
`default_nettype none

module inst_cache (
	input  logic        clock,
	input  logic        rst,

	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,

	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready
);

	import fetch_pkg::*;

	logic [cache_lines-1:0] line_valid;
	logic [tag_bits-1:0]    tag_mem  [cache_lines];
	logic [31:0]            data_mem [cache_lines];
	logic                   idle;
	logic                   rd_fire;
	logic                   wr_fire;
	logic [index_bits-1:0]  rd_index;
	logic [tag_bits-1:0]    rd_tag;
	logic [index_bits-1:0]  wr_index;
	logic [tag_bits-1:0]    wr_tag;
	logic                   rd_hit;

	// Idle means no response is being presented
	assign idle    = !rvalid && !bvalid;
	assign arready = idle;

	// Reads win if both channels ask in the same cycle
	assign awready = idle && !arvalid;
	assign wready  = idle && !arvalid;

	assign rd_fire = arvalid && arready;
	assign wr_fire = awvalid && awready && wvalid && wready;

	assign rd_index = araddr[index_bits+1:2];
	assign rd_tag   = araddr[31 -: tag_bits];
	assign wr_index = awaddr[index_bits+1:2];
	assign wr_tag   = awaddr[31 -: tag_bits];

	assign rd_hit = line_valid[rd_index] && (tag_mem[rd_index] == rd_tag);

	assign bresp = resp_okay;

	// ######################################################################
	// Response handshakes
	// ######################################################################

	always_ff @(posedge clock) begin
		if (rst) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// Valid bits, the only array state cleared by reset
	always_ff @(posedge clock) begin
		if (rst)
			line_valid <= '0;
		else if (wr_fire)
			line_valid[wr_index] <= 1'b1;
	end

	// ######################################################################
	// Tag and data arrays
	// ######################################################################

	always_ff @(posedge clock) begin
		if (wr_fire) begin
			tag_mem[wr_index]  <= wr_tag;
			data_mem[wr_index] <= wdata;
		end
		if (rd_fire) begin
			// Miss returns zero data
			rdata <= rd_hit ? data_mem[rd_index] : 32'h0;
			rresp <= rd_hit ? resp_okay : resp_miss;
		end
	end

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	// ######################################################################
	// Address map
	// ######################################################################

	// On-chip SRAM window, fetched without the cache
	localparam logic [31:0] sram_base  = 32'h0f000000;
	localparam logic [31:0] sram_limit = 32'h0f002000;

	// ######################################################################
	// Cache geometry
	// ######################################################################

	// One word per line, index from bits 5..2, tag from bits 31..6
	localparam int cache_lines = 16;
	localparam int index_bits  = 4;
	localparam int tag_bits    = 26;

	// Read response codes, bit 1 flags a miss
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_miss = 2'b10;

	// ######################################################################
	// Fetch FSM
	// ######################################################################

	typedef enum logic [2:0] {
		st_idle,
		st_cache_addr,
		st_cache_resp,
		st_mem_addr,
		st_mem_resp,
		st_fill,
		st_done
	} fetch_state_t;

endpackage

`default_nettype wire
